/* Makefile */
all: run

obj_dir/Vvideo_normalizer_tb: video_normalizer.f hw/*.sv verification/*.sv
	verilator --binary --timing --assert -f video_normalizer.f --top-module video_normalizer_tb

run: obj_dir/Vvideo_normalizer_tb
	obj_dir/Vvideo_normalizer_tb | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only --timing -f video_normalizer.f --top-module video_normalizer_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

/* hw/normalizer_cfg_regs.sv */
// write-only register bank for enable, frame size, fill color and stall timeout
module normalizer_cfg_regs (
	input  logic                                           aclk,
	input  logic                                           aresetn,

	input  logic                                           cfg_we,
	input  logic [video_normalizer_pkg::cfg_addr_width-1:0] cfg_addr,
	input  logic [video_normalizer_pkg::cfg_data_width-1:0] cfg_wdata,

	output logic                                           param_enable,
	output logic [video_normalizer_pkg::x_width-1:0]        param_width,
	output logic [video_normalizer_pkg::y_width-1:0]        param_height,
	output logic [video_normalizer_pkg::tdata_width-1:0]    param_fill,
	output logic [video_normalizer_pkg::timer_width-1:0]    param_timeout
);

	// --------------------
	// write decode
	// --------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			param_enable <= 1'b0;
			param_width <= '0;
			param_height <= '0;
			param_fill <= '0;
			param_timeout <= '0;
		end else if (cfg_we) begin
			case (cfg_addr)
				video_normalizer_pkg::addr_control: begin
					param_enable <= cfg_wdata[0];
				end
				video_normalizer_pkg::addr_size: begin
					// height sits in the upper half word
					param_width <= cfg_wdata[video_normalizer_pkg::x_width-1:0];
					param_height <= cfg_wdata[16 +: video_normalizer_pkg::y_width];
				end
				video_normalizer_pkg::addr_fill: begin
					param_fill <= cfg_wdata[video_normalizer_pkg::tdata_width-1:0];
				end
				video_normalizer_pkg::addr_timeout: begin
					param_timeout <= cfg_wdata[video_normalizer_pkg::timer_width-1:0];
				end
			endcase
		end
	end

endmodule

/* hw/pipeline_skid_ff.sv */
// two-entry skid register with registered ready for a valid/ready stream
module pipeline_skid_ff #(
	parameter int data_width = 32
) (
	input  logic                  aclk,
	input  logic                  aresetn,

	input  logic [data_width-1:0] s_data,
	input  logic                  s_valid,
	output logic                  s_ready,

	output logic [data_width-1:0] m_data,
	output logic                  m_valid,
	input  logic                  m_ready
);

	// spare entry, only filled when the output stage is stuck
	logic [data_width-1:0] skid_data;
	logic                  skid_valid;

	// output stage can take a new beat this cycle
	logic                  m_load;
	logic                  s_take;

	// ready comes straight from a flop
	assign s_ready = ~skid_valid;

	assign m_load = m_ready || !m_valid;
	assign s_take = s_valid && s_ready;

	// --------------------
	// occupancy
	// --------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			m_valid <= 1'b0;
			skid_valid <= 1'b0;
		end else if (m_load) begin
			if (skid_valid) begin
				// drain the spare first, keeps order
				m_valid <= 1'b1;
				skid_valid <= 1'b0;
			end else begin
				m_valid <= s_take;
			end
		end else if (s_take) begin
			// output held, park the beat
			skid_valid <= 1'b1;
		end
	end

	// --------------------
	// payload
	// --------------------
	always_ff @(posedge aclk) begin
		if (m_load) begin
			if (skid_valid) begin
				m_data <= skid_data;
			end else if (s_take) begin
				m_data <= s_data;
			end
		end else if (s_take) begin
			skid_data <= s_data;
		end
	end

endmodule

/* hw/video_normalizer.sv */
// top level with register bank, input and output skid registers and normalizer core
module video_normalizer (
	input  logic                                           aclk,
	input  logic                                           aresetn,

	input  logic                                           cfg_we,
	input  logic [video_normalizer_pkg::cfg_addr_width-1:0] cfg_addr,
	input  logic [video_normalizer_pkg::cfg_data_width-1:0] cfg_wdata,

	input  logic [video_normalizer_pkg::tuser_width-1:0]    s_tuser,
	input  logic                                           s_tlast,
	input  logic [video_normalizer_pkg::tdata_width-1:0]    s_tdata,
	input  logic                                           s_tvalid,
	output logic                                           s_tready,

	output logic [video_normalizer_pkg::tuser_width-1:0]    m_tuser,
	output logic                                           m_tlast,
	output logic [video_normalizer_pkg::tdata_width-1:0]    m_tdata,
	output logic                                           m_tvalid,
	input  logic                                           m_tready
);

	// register bank to core
	logic                                        param_enable;
	logic [video_normalizer_pkg::x_width-1:0]     param_width;
	logic [video_normalizer_pkg::y_width-1:0]     param_height;
	logic [video_normalizer_pkg::tdata_width-1:0] param_fill;
	logic [video_normalizer_pkg::timer_width-1:0] param_timeout;

	// input skid to core
	logic [video_normalizer_pkg::tuser_width-1:0] in_tuser;
	logic                                        in_tlast;
	logic [video_normalizer_pkg::tdata_width-1:0] in_tdata;
	logic                                        in_tvalid;
	logic                                        in_tready;

	// core to output skid
	logic [video_normalizer_pkg::tuser_width-1:0] out_tuser;
	logic                                        out_tlast;
	logic [video_normalizer_pkg::tdata_width-1:0] out_tdata;
	logic                                        out_tvalid;
	logic                                        out_tready;

	normalizer_cfg_regs u_cfg (
		.aclk(aclk), .aresetn(aresetn),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.param_enable(param_enable), .param_width(param_width),
		.param_height(param_height), .param_fill(param_fill),
		.param_timeout(param_timeout)
	);

	pipeline_skid_ff #(.data_width(video_normalizer_pkg::stream_width)) u_skid_in (
		.aclk(aclk), .aresetn(aresetn),
		.s_data({s_tuser, s_tlast, s_tdata}), .s_valid(s_tvalid), .s_ready(s_tready),
		.m_data({in_tuser, in_tlast, in_tdata}), .m_valid(in_tvalid), .m_ready(in_tready)
	);

	video_normalizer_core u_core (
		.aclk(aclk), .aresetn(aresetn),
		.param_enable(param_enable), .param_width(param_width),
		.param_height(param_height), .param_fill(param_fill),
		.param_timeout(param_timeout),
		.in_tuser(in_tuser), .in_tlast(in_tlast), .in_tdata(in_tdata),
		.in_tvalid(in_tvalid), .in_tready(in_tready),
		.out_tuser(out_tuser), .out_tlast(out_tlast), .out_tdata(out_tdata),
		.out_tvalid(out_tvalid), .out_tready(out_tready)
	);

	pipeline_skid_ff #(.data_width(video_normalizer_pkg::stream_width)) u_skid_out (
		.aclk(aclk), .aresetn(aresetn),
		.s_data({out_tuser, out_tlast, out_tdata}), .s_valid(out_tvalid),
		.s_ready(out_tready),
		.m_data({m_tuser, m_tlast, m_tdata}), .m_valid(m_tvalid), .m_ready(m_tready)
	);

endmodule

/* hw/video_normalizer_core.sv */
// frame normalizer FSM with crop, horizontal and vertical fill, and stall timeout
module video_normalizer_core (
	input  logic                                        aclk,
	input  logic                                        aresetn,

	input  logic                                        param_enable,
	input  logic [video_normalizer_pkg::x_width-1:0]     param_width,
	input  logic [video_normalizer_pkg::y_width-1:0]     param_height,
	input  logic [video_normalizer_pkg::tdata_width-1:0] param_fill,
	input  logic [video_normalizer_pkg::timer_width-1:0] param_timeout,

	input  logic [video_normalizer_pkg::tuser_width-1:0] in_tuser,
	input  logic                                        in_tlast,
	input  logic [video_normalizer_pkg::tdata_width-1:0] in_tdata,
	input  logic                                        in_tvalid,
	output logic                                        in_tready,

	output logic [video_normalizer_pkg::tuser_width-1:0] out_tuser,
	output logic                                        out_tlast,
	output logic [video_normalizer_pkg::tdata_width-1:0] out_tdata,
	output logic                                        out_tvalid,
	input  logic                                        out_tready
);

	// frame state
	logic busy;
	logic skip;
	logic fill_h;
	logic fill_v;
	logic [video_normalizer_pkg::timer_width-1:0] timer;
	logic [video_normalizer_pkg::x_width-1:0] x;
	logic [video_normalizer_pkg::y_width-1:0] y;

	// settings captured at frame start
	logic [video_normalizer_pkg::x_width-1:0] w_last;
	logic [video_normalizer_pkg::y_width-1:0] h_last;
	logic [video_normalizer_pkg::tdata_width-1:0] fill_color;
	logic [video_normalizer_pkg::timer_width-1:0] timeout;

	// limits in effect this cycle
	logic [video_normalizer_pkg::x_width-1:0] w_last_cur;
	logic [video_normalizer_pkg::y_width-1:0] h_last_cur;

	logic cke;
	logic in_take;
	logic start;
	logic pass;
	logic fill_beat;
	logic gen;
	logic x_last;
	logic y_last;
	logic frame_done;

	// --------------------
	// beat generation
	// --------------------
	// everything freezes while the output register is held
	assign cke = !out_tvalid || out_tready;

	// when idle the start beat itself is pixel (0,0), so use the live settings
	assign w_last_cur = busy ? w_last : param_width - 1'b1;
	assign h_last_cur = busy ? h_last : param_height - 1'b1;
	assign x_last = (x == w_last_cur);
	assign y_last = (y == h_last_cur);

	// a start beat is never consumed mid-frame, it waits for the frame end
	assign in_tready = cke && (busy ?
		(!in_tuser[0] && (skip || (!fill_h && !fill_v))) :
		(!in_tuser[0] || param_enable));

	assign in_take = in_tvalid && in_tready;
	assign start = !busy && in_take && in_tuser[0];
	assign pass = start || (busy && in_take && !skip && !fill_h && !fill_v);
	assign fill_beat = cke && busy && (fill_h || fill_v);
	assign gen = pass || fill_beat;
	assign frame_done = gen && x_last && y_last;

	// --------------------
	// control
	// --------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			busy <= 1'b0;
			skip <= 1'b0;
			fill_h <= 1'b0;
			fill_v <= 1'b0;
			timer <= '0;
			x <= '0;
			y <= '0;
			out_tvalid <= 1'b0;
		end else if (cke) begin
			out_tvalid <= gen;

			if (start) begin
				busy <= 1'b1;
				skip <= 1'b0;
				fill_h <= 1'b0;
				fill_v <= 1'b0;
			end

			// input line ran past the crop, drop until tlast
			if (skip && in_take && in_tlast) begin
				skip <= 1'b0;
			end

			// x/y walk and line transitions
			if (gen) begin
				if (x_last) begin
					x <= '0;
					y <= y + 1'b1;
					fill_h <= 1'b0;
					if (pass && !in_tlast) begin
						skip <= 1'b1;
					end
				end else begin
					x <= x + 1'b1;
					// short line
					if (pass && in_tlast) begin
						fill_h <= 1'b1;
					end
				end
			end

			// next frame already waiting, pad out the rest of this one
			if (busy && in_tvalid && in_tuser[0]) begin
				fill_v <= 1'b1;
			end

			// stall timer, only runs while the input is empty
			if (!busy || in_tvalid) begin
				timer <= '0;
			end else begin
				timer <= timer + 1'b1;
				if (timer == timeout) begin
					skip <= 1'b1;
					fill_h <= 1'b1;
					fill_v <= 1'b1;
				end
			end

			// last beat of the output frame wins over everything above
			if (frame_done) begin
				busy <= 1'b0;
				skip <= 1'b0;
				fill_h <= 1'b0;
				fill_v <= 1'b0;
				timer <= '0;
				x <= '0;
				y <= '0;
			end
		end
	end

	// --------------------
	// settings and output payload
	// --------------------
	always_ff @(posedge aclk) begin
		if (start) begin
			w_last <= param_width - 1'b1;
			h_last <= param_height - 1'b1;
			fill_color <= param_fill;
			timeout <= param_timeout;
		end
		if (gen) begin
			out_tuser <= '0;
			out_tuser[0] <= (x == '0) && (y == '0);
			out_tlast <= x_last;
			out_tdata <= fill_beat ? fill_color : in_tdata;
		end
	end

endmodule

/* hw/video_normalizer_pkg.sv */
// shared widths, stream beat layout and configuration register map
package video_normalizer_pkg;

	// --------------------
	// stream widths
	// --------------------
	localparam int tdata_width = 24;
	// bit 0 is start of frame
	localparam int tuser_width = 1;
	// packed beat is {tuser, tlast, tdata}
	localparam int stream_width = tuser_width + 1 + tdata_width;

	// --------------------
	// counters and timer
	// --------------------
	localparam int x_width = 12;
	localparam int y_width = 12;
	localparam int timer_width = 32;

	// --------------------
	// configuration port
	// --------------------
	localparam int cfg_addr_width = 2;
	localparam int cfg_data_width = 32;

	// bit 0 enable
	localparam logic [cfg_addr_width-1:0] addr_control = 2'd0;
	// width in 11..0, height in 27..16
	localparam logic [cfg_addr_width-1:0] addr_size = 2'd1;
	// fill color in 23..0
	localparam logic [cfg_addr_width-1:0] addr_fill = 2'd2;
	localparam logic [cfg_addr_width-1:0] addr_timeout = 2'd3;

endpackage

/* verification/normalizer_assertions.sv */
// concurrent checks on the core output stream, its reset state and frame start marking
module normalizer_assertions (
	input logic                                        aclk,
	input logic                                        aresetn,
	input logic                                        out_tvalid,
	input logic                                        out_tready,
	input logic [video_normalizer_pkg::tuser_width-1:0] out_tuser,
	input logic                                        out_tlast,
	input logic [video_normalizer_pkg::tdata_width-1:0] out_tdata
);
	timeunit 1ns;
	timeprecision 100ps;

	// previous output beat left its line open
	logic mid_line;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			mid_line <= 1'b0;
		end else if (out_tvalid && out_tready) begin
			mid_line <= !out_tlast;
		end
	end

	// --------------------
	// reset and protocol
	// --------------------
	reset_clears_valid: assert property (@(posedge aclk) !aresetn |=> !out_tvalid)
		else $error("core output valid is high after reset");

	// a held beat keeps valid and its payload
	stalled_beat_stable: assert property (@(posedge aclk) disable iff (!aresetn)
		out_tvalid && !out_tready |=>
		out_tvalid && $stable(out_tdata) && $stable(out_tlast) && $stable(out_tuser))
		else $error("core output changed while stalled");

	// frame start only at column zero
	tuser_at_column_zero: assert property (@(posedge aclk) disable iff (!aresetn)
		out_tvalid && mid_line |-> !out_tuser[0])
		else $error("core output tuser set on a nonzero column");

endmodule

bind video_normalizer_core normalizer_assertions u_assertions (
	.aclk(aclk),
	.aresetn(aresetn),
	.out_tvalid(out_tvalid),
	.out_tready(out_tready),
	.out_tuser(out_tuser),
	.out_tlast(out_tlast),
	.out_tdata(out_tdata)
);

/* verification/normalizer_checker.sv */
// output stream checker with expected frame model, per-test report and counts
module normalizer_checker (
	input logic                                        aclk,
	input logic                                        aresetn,
	input logic [video_normalizer_pkg::tuser_width-1:0] m_tuser,
	input logic                                        m_tlast,
	input logic [video_normalizer_pkg::tdata_width-1:0] m_tdata,
	input logic                                        m_tvalid,
	input logic                                        m_tready
);
	timeunit 1ns;
	timeprecision 100ps;

	// input frame as driven, indexed by beat
	logic [video_normalizer_pkg::tdata_width-1:0] in_pixels[$];
	logic [video_normalizer_pkg::tdata_width-1:0] fill_color;
	logic armed = 1'b0;
	int test_id;
	int out_w;
	int out_h;
	int in_w;
	// input beats that reach the core before any timeout
	int usable;
	int exp_beats;
	int exp_fill;
	int beat_idx = 0;
	int fill_count = 0;
	int test_errors = 0;
	int frames_done = 0;
	int pass_count = 0;
	int fail_count = 0;
	int stray_count = 0;

	task automatic expect_frame(input int t, input int w, input int h,
		input logic [video_normalizer_pkg::tdata_width-1:0] f, input int iw,
		input int use_n, input int eb, input int ef);
		in_pixels.delete();
		test_id = t;
		out_w = w;
		out_h = h;
		fill_color = f;
		in_w = iw;
		usable = use_n;
		exp_beats = eb;
		exp_fill = ef;
		beat_idx = 0;
		fill_count = 0;
		test_errors = 0;
		armed = 1'b1;
	endtask

	task automatic add_pixel(input logic [video_normalizer_pkg::tdata_width-1:0] p);
		in_pixels.push_back(p);
	endtask

	task automatic report_error(input string msg);
		$display("Error: %0d ns: test %0d beat %0d: %s", $time, test_id, beat_idx, msg);
		test_errors++;
	endtask

	task automatic finish_frame();
		if (beat_idx != exp_beats)
			report_error($sformatf("%0d beats, vector gives %0d", beat_idx, exp_beats));
		if (fill_count != exp_fill)
			report_error($sformatf("%0d fill beats, vector gives %0d", fill_count, exp_fill));
		if (test_errors == 0) begin
			pass_count++;
			$display("test %0d: ok, %0d beats, %0d fill", test_id, beat_idx, fill_count);
		end else begin
			fail_count++;
			$display("test %0d: failed with %0d errors", test_id, test_errors);
		end
		frames_done++;
		armed = 1'b0;
	endtask

	// --------------------
	// beat compare
	// --------------------
	task automatic check_beat();
		int bx;
		int by;
		int src;
		logic from_input;
		logic [video_normalizer_pkg::tdata_width-1:0] want;
		bx = beat_idx % out_w;
		by = beat_idx / out_w;
		src = by * in_w + bx;
		// crop on the right, timeout or short frame at the bottom
		from_input = (bx < in_w) && (src < usable);
		want = from_input ? in_pixels[src] : fill_color;
		if (!from_input)
			fill_count++;
		if (m_tdata !== want)
			report_error($sformatf("tdata %06h, expected %06h", m_tdata, want));
		if (m_tuser[0] !== (beat_idx == 0))
			report_error("tuser on the wrong beat");
		if (m_tlast !== (bx == out_w - 1))
			report_error("tlast on the wrong beat");
		beat_idx++;
		if (beat_idx == out_w * out_h)
			finish_frame();
	endtask

	always @(posedge aclk) begin
		if (aresetn && m_tvalid && m_tready) begin
			if (!armed) begin
				stray_count++;
				$display("an output beat appeared at %0d ns while no frame was expected", $time);
			end else begin
				check_beat();
			end
		end
	end

endmodule

/* verification/normalizer_vectors.txt */
# enable width height fill(hex) timeout in_width in_height stall_after stall_len backpressure
# expected_beats expected_fill (stall_len 0 means the input never stalls)
1 8 4 0000ff 40 8 4 0 0 0 32 0
1 6 3 00ff00 40 10 5 0 0 0 18 0
1 8 4 123456 40 5 4 0 0 0 32 12
1 6 5 abcdef 30 6 3 0 0 0 30 12
1 8 6 0f0f0f 30 5 4 0 0 0 48 28
1 8 4 f00000 60 8 4 10 12 0 32 0
1 8 4 00aa55 20 8 4 13 80 0 32 18
1 8 4 777777 200 8 4 0 0 1 32 0
1 6 5 c0ffee 200 9 3 0 0 1 30 12
1 7 3 5a5a5a 200 4 3 0 0 1 21 9
0 4 2 314159 40 4 2 0 0 0 8 0
1 1 1 fedcba 10 3 2 0 0 0 1 0

/* verification/video_normalizer_tb.sv */
// testbench top with clock, reset, register setup, vector driven stimulus and run limit
module video_normalizer_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int max_tests = 32;
	localparam logic [31:0] seed = 32'hb9b5f41d;

	// vector columns
	localparam int col_enable = 0;
	localparam int col_width = 1;
	localparam int col_height = 2;
	localparam int col_fill = 3;
	localparam int col_timeout = 4;
	localparam int col_in_w = 5;
	localparam int col_in_h = 6;
	localparam int col_stall_at = 7;
	localparam int col_stall_len = 8;
	localparam int col_bp = 9;
	localparam int col_beats = 10;
	localparam int col_fills = 11;

	logic aclk = 1'b0;
	logic aresetn;
	logic cfg_we;
	logic [video_normalizer_pkg::cfg_addr_width-1:0] cfg_addr;
	logic [video_normalizer_pkg::cfg_data_width-1:0] cfg_wdata;
	logic [video_normalizer_pkg::tuser_width-1:0] s_tuser;
	logic s_tlast;
	logic [video_normalizer_pkg::tdata_width-1:0] s_tdata;
	logic s_tvalid;
	logic s_tready;
	logic [video_normalizer_pkg::tuser_width-1:0] m_tuser;
	logic m_tlast;
	logic [video_normalizer_pkg::tdata_width-1:0] m_tdata;
	logic m_tvalid;
	logic m_tready = 1'b1;

	int vec[max_tests][12];
	int num_tests = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	logic backpressure = 1'b0;
	logic [31:0] pixel_state;
	logic [31:0] ready_state;
	logic [video_normalizer_pkg::tdata_width-1:0] frame_pixels[$];

	always #10 aclk = ~aclk;

	video_normalizer u_dut (
		.aclk(aclk), .aresetn(aresetn),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.s_tuser(s_tuser), .s_tlast(s_tlast), .s_tdata(s_tdata),
		.s_tvalid(s_tvalid), .s_tready(s_tready),
		.m_tuser(m_tuser), .m_tlast(m_tlast), .m_tdata(m_tdata),
		.m_tvalid(m_tvalid), .m_tready(m_tready)
	);

	normalizer_checker u_checker (
		.aclk(aclk), .aresetn(aresetn),
		.m_tuser(m_tuser), .m_tlast(m_tlast), .m_tdata(m_tdata),
		.m_tvalid(m_tvalid), .m_tready(m_tready)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// --------------------
	// run limit
	// --------------------
	always @(posedge aclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the run went past %0d cycles without finishing", cycle_limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// random output back-pressure
	always @(posedge aclk) begin
		if (!aresetn) begin
			ready_state <= xorshift32(seed);
			m_tready <= 1'b1;
		end else if (backpressure) begin
			ready_state <= xorshift32(ready_state);
			m_tready <= ready_state[4];
		end else begin
			m_tready <= 1'b1;
		end
	end

	task automatic load_vectors();
		int fd;
		int code;
		string line;
		fd = $fopen("verification/normalizer_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vectors file");
		end else begin
			while (!$feof(fd) && num_tests < max_tests) begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
					code = $sscanf(line, "%d %d %d %h %d %d %d %d %d %d %d %d",
						vec[num_tests][0], vec[num_tests][1], vec[num_tests][2],
						vec[num_tests][3], vec[num_tests][4], vec[num_tests][5],
						vec[num_tests][6], vec[num_tests][7], vec[num_tests][8],
						vec[num_tests][9], vec[num_tests][10], vec[num_tests][11]);
					if (code == 12)
						num_tests++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic release_reset();
		repeat (8) @(posedge aclk);
		aresetn <= 1'b1;
	endtask

	task automatic write_reg(input logic [video_normalizer_pkg::cfg_addr_width-1:0] addr,
		input logic [31:0] data);
		@(posedge aclk);
		cfg_we <= 1'b1;
		cfg_addr <= addr;
		cfg_wdata <= data;
		@(posedge aclk);
		cfg_we <= 1'b0;
	endtask

	task automatic send_beat(input logic [23:0] data, input logic first, input logic last);
		s_tdata <= data;
		s_tuser <= first;
		s_tlast <= last;
		s_tvalid <= 1'b1;
		@(posedge aclk);
		while (!s_tready) begin
			@(posedge aclk);
		end
	endtask

	task automatic drive_frame(input int iw, input int ih, input int stall_at,
		input int stall_len);
		for (int idx = 0; idx < iw * ih; idx++) begin
			send_beat(frame_pixels[idx], idx == 0, (idx % iw) == iw - 1);
			// input gap after the given beat
			if (stall_len > 0 && idx == stall_at) begin
				s_tvalid <= 1'b0;
				repeat (stall_len) @(posedge aclk);
			end
		end
		s_tvalid <= 1'b0;
	endtask

	// frame start must be held off until enable is written
	task automatic hold_then_enable();
		repeat (50) @(posedge aclk);
		if (s_tready)
			u_checker.report_error("s_tready stayed high at a frame start while disabled");
		if (u_checker.beat_idx != 0)
			u_checker.report_error("output appeared while disabled");
		write_reg(video_normalizer_pkg::addr_control, 32'd1);
	endtask

	task automatic run_test(input int t);
		int iw;
		int ih;
		int usable;
		logic [31:0] size_word;
		iw = vec[t][col_in_w];
		ih = vec[t][col_in_h];
		// a stall past the timeout cuts the input after the stalled beat
		if (vec[t][col_stall_len] > vec[t][col_timeout])
			usable = vec[t][col_stall_at] + 1;
		else
			usable = iw * ih;
		u_checker.expect_frame(t, vec[t][col_width], vec[t][col_height],
			vec[t][col_fill][23:0], iw, usable, vec[t][col_beats], vec[t][col_fills]);
		frame_pixels.delete();
		for (int idx = 0; idx < iw * ih; idx++) begin
			pixel_state = xorshift32(pixel_state);
			frame_pixels.push_back(pixel_state[23:0]);
			u_checker.add_pixel(pixel_state[23:0]);
		end
		backpressure <= (vec[t][col_bp] != 0);
		size_word = (vec[t][col_height] << 16) | vec[t][col_width];
		write_reg(video_normalizer_pkg::addr_size, size_word);
		write_reg(video_normalizer_pkg::addr_fill, vec[t][col_fill]);
		write_reg(video_normalizer_pkg::addr_timeout, vec[t][col_timeout]);
		write_reg(video_normalizer_pkg::addr_control, vec[t][col_enable]);
		if (vec[t][col_enable] != 0) begin
			drive_frame(iw, ih, vec[t][col_stall_at], vec[t][col_stall_len]);
		end else begin
			fork
				drive_frame(iw, ih, vec[t][col_stall_at], vec[t][col_stall_len]);
				hold_then_enable();
			join
		end
		while (u_checker.frames_done < t + 1) begin
			@(posedge aclk);
		end
		repeat (4) @(posedge aclk);
	endtask

	initial begin
		int limit;
		aresetn = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		s_tuser = '0;
		s_tlast = 1'b0;
		s_tdata = '0;
		s_tvalid = 1'b0;
		pixel_state = seed;
		load_vectors();
		limit = 1000;
		for (int t = 0; t < num_tests; t++) begin
			limit += (vec[t][col_width] * vec[t][col_height]
				+ vec[t][col_in_w] * vec[t][col_in_h] + vec[t][col_stall_len]) * 4;
		end
		cycle_limit = limit;
		release_reset();
		for (int t = 0; t < num_tests; t++) begin
			run_test(t);
		end
		$display("tests: %0d passed, %0d failed, %0d stray beats",
			u_checker.pass_count, u_checker.fail_count, u_checker.stray_count);
		if (num_tests > 0 && u_checker.fail_count == 0 && u_checker.stray_count == 0
			&& u_checker.pass_count == num_tests) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* video_normalizer.f */
hw/video_normalizer_pkg.sv
hw/pipeline_skid_ff.sv
hw/normalizer_cfg_regs.sv
hw/video_normalizer_core.sv
hw/video_normalizer.sv
verification/normalizer_assertions.sv
verification/normalizer_checker.sv
verification/video_normalizer_tb.sv
